//--- audio_path.f
+incdir+verilog
+incdir+dv
verilog/audio_types_pkg.sv
verilog/audio_ctrl_pkg.sv
verilog/audio_stream_if.sv
verilog/audio_cfg_regs.sv
verilog/audio_mixer.sv
verilog/audio_compressor.sv
verilog/audio_top.sv
dv/audio_tb.sv

//--- dv/audio_model.svh
`ifndef AUDIO_MODEL_SVH
`define AUDIO_MODEL_SVH

// PSG level is 1/2 + 1/4 + 1/16, each term floored
function automatic int psg_level(input sample_t s);
	int v;
	v = int'(s);
	return (v >>> 1) + (v >>> 2) + (v >>> 4);
endfunction

// ADPCM level is 1/2 + 1/4 + 1/8
function automatic int adpcm_level(input sample_t s);
	int v;
	v = int'(s);
	return (v >>> 1) + (v >>> 2) + (v >>> 3);
endfunction

// Low 18 bits taken as a signed value
function automatic int wrap18(input int v);
	logic signed [17:0] t;
	t = 18'(v);
	return int'(t);
endfunction

// en bit 0 CD, bit 1 PSG, bit 2 ADPCM
function automatic sample_t mix_channel(input sample_t cd, input sample_t psg,
		input sample_t adp, input logic [2:0] en, input logic cd_boost);
	int sum;
	sum = 0;
	if (en[0])
		sum += int'(cd);
	if (en[0] && cd_boost)
		sum += int'(cd);
	if (en[1])
		sum += psg_level(psg);
	if (en[2])
		sum += adpcm_level(adp);
	sum = wrap18(sum);
	if (!cd_boost)
		sum = wrap18(sum + (sum >>> 2));
	// Upper 16 of the 18 bits
	return sample_t'(sum >>> 2);
endfunction

// Mode 1 is curve 1, mode 2 is curve 2, anything else passes through
function automatic sample_t knee_curve(input sample_t s, input logic [1:0] mode);
	int v;
	int mag;
	int res;
	int knee;
	int base;
	int gain;
	int fall;
	v = int'(s);
	if (mode == 2'd1) begin
		knee = int'(`AUDIO_COMP1_KNEE);
		base = int'(`AUDIO_COMP1_BASE);
		gain = int'(`AUDIO_COMP1_GAIN);
		fall = int'(`AUDIO_COMP1_FALL);
	end else if (mode == 2'd2) begin
		knee = int'(`AUDIO_COMP2_KNEE);
		base = int'(`AUDIO_COMP2_BASE);
		gain = int'(`AUDIO_COMP2_GAIN);
		fall = int'(`AUDIO_COMP2_FALL);
	end else begin
		return s;
	end
	mag = (v < 0) ? -v : v;
	if (mag < knee)
		res = mag * gain;
	else
		res = (mag - knee) / fall + base;
	res = res & 32'hffff;
	if (v < 0)
		res = -res;
	return sample_t'(res);
endfunction

`endif

//--- dv/audio_tb.sv
`timescale 1ns/1ps
`include "audio_config.svh"

module audio_tb;
	import audio_types_pkg::*;
	import audio_ctrl_pkg::*;

	`include "audio_model.svh"

	localparam int PERIOD = 40;
	// Beats per test group
	localparam int N_DEFAULT = 200;
	localparam int N_EN = 8 * 60;
	localparam int N_CDB = 40 + 6;
	localparam int N_COMP = 2 * (50 + 6 + 3);
	localparam int N_ILLEGAL = 20;
	localparam int N_BP = 300;
	localparam int TOTAL_BEATS = N_DEFAULT + N_EN + N_CDB + N_COMP + N_ILLEGAL + N_BP;
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 3 * 8 + 2000;

	logic       clk_sys;
	logic       reset;
	logic       cfg_wr;
	cfg_addr_e  cfg_addr;
	logic [7:0] cfg_wdata;
	logic [7:0] cfg_rdata;
	logic       in_valid;
	logic       in_ready;
	sample_t    cdda_l;
	sample_t    cdda_r;
	sample_t    psg_l;
	sample_t    psg_r;
	sample_t    adpcm;
	logic       out_valid;
	logic       out_ready;
	sample_t    out_l;
	sample_t    out_r;

	integer     seed = 32'h1fde;
	// Copy of the register contents
	logic [2:0] sh_src_en;
	logic       sh_cd_boost;
	logic [1:0] sh_boost;
	logic       backpressure;
	logic       stall_seen;
	sample_t    stall_l;
	sample_t    stall_r;
	sample_t    exp_l_q[$];
	sample_t    exp_r_q[$];

	audio_top dut_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.cdda_l    (cdda_l),
		.cdda_r    (cdda_r),
		.psg_l     (psg_l),
		.psg_r     (psg_r),
		.adpcm     (adpcm),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_l     (out_l),
		.out_r     (out_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		fail_now("Timeout: the pipeline stalled before all beats came out");
	end

	function automatic sample_t rand_sample();
		return sample_t'($random(seed));
	endfunction

	// Roughly 40% of cycles stall the output when enabled
	function automatic logic next_ready();
		return backpressure ? (($random(seed) & 255) >= 102) : 1'b1;
	endfunction

	function automatic sample_t expect_out(input sample_t cd, input sample_t psg,
			input sample_t adp);
		return knee_curve(mix_channel(cd, psg, adp, sh_src_en, sh_cd_boost), sh_boost);
	endfunction

	////////////////////////////////////////
	// Per-cycle scoreboard
	////////////////////////////////////////

	// Runs mid low phase, after inputs and DUT outputs have settled
	task automatic check_cycle();
		sample_t exp_l;
		sample_t exp_r;
		if (stall_seen)
			assert (out_valid && out_l == stall_l && out_r == stall_r)
			else fail_now($sformatf("Stalled output beat was dropped or changed at %0t", $time));
		if (in_valid && in_ready) begin
			exp_l_q.push_back(expect_out(cdda_l, psg_l, adpcm));
			exp_r_q.push_back(expect_out(cdda_r, psg_r, adpcm));
		end
		if (out_valid && out_ready) begin
			assert (exp_l_q.size() > 0)
			else fail_now("An output beat came out that was never sent in");
			exp_l = exp_l_q.pop_front();
			exp_r = exp_r_q.pop_front();
			assert (out_l == exp_l && out_r == exp_r)
			else fail_now($sformatf("FAILED at %0t: expected L %0d R %0d, got L %0d R %0d",
				$time, exp_l, exp_r, out_l, out_r));
		end
		stall_seen = out_valid && !out_ready;
		stall_l = out_l;
		stall_r = out_r;
	endtask

	task automatic idle_cycle();
		@(negedge clk_sys);
		in_valid = 1'b0;
		out_ready = next_ready();
		#1;
		check_cycle();
	endtask

	// Holds the beat until the DUT takes it
	task automatic send_beat(input sample_t cl, input sample_t cr, input sample_t pl,
			input sample_t pr, input sample_t ad);
		logic accepted;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk_sys);
			in_valid = 1'b1;
			cdda_l = cl;
			cdda_r = cr;
			psg_l = pl;
			psg_r = pr;
			adpcm = ad;
			out_ready = next_ready();
			#1;
			accepted = in_ready;
			check_cycle();
		end
	endtask

	task automatic send_random(input int n, input logic gaps);
		repeat (n) begin
			if (gaps && ($random(seed) & 3) == 0)
				idle_cycle();
			send_beat(rand_sample(), rand_sample(), rand_sample(), rand_sample(),
				rand_sample());
		end
	endtask

	task automatic drain();
		while (exp_l_q.size() > 0)
			idle_cycle();
	endtask

	////////////////////////////////////////
	// Register access
	////////////////////////////////////////

	task automatic write_reg(input cfg_addr_e addr, input logic [7:0] data);
		@(negedge clk_sys);
		in_valid = 1'b0;
		out_ready = 1'b1;
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		#1;
		check_cycle();
		@(negedge clk_sys);
		cfg_wr = 1'b0;
		if (addr == REG_SRC_EN) begin
			sh_src_en = data[2:0];
		end else begin
			sh_cd_boost = data[0];
			// Code 3 is stored as no boost
			sh_boost = (data[2:1] == 2'd3) ? 2'd0 : data[2:1];
		end
	endtask

	task automatic check_regs();
		@(negedge clk_sys);
		cfg_addr = REG_SRC_EN;
		#1;
		assert (cfg_rdata == {5'b0, sh_src_en})
		else fail_now($sformatf("FAILED at %0t: source enable read %h, expected %h",
			$time, cfg_rdata, {5'b0, sh_src_en}));
		@(negedge clk_sys);
		cfg_addr = REG_BOOST;
		#1;
		assert (cfg_rdata == {5'b0, sh_boost, sh_cd_boost})
		else fail_now($sformatf("FAILED at %0t: boost read %h, expected %h",
			$time, cfg_rdata, {5'b0, sh_boost, sh_cd_boost}));
	endtask

	// All sources at the rails
	task automatic full_scale_beats();
		send_beat(16'sd32767, 16'sd32767, 16'sd32767, 16'sd32767, 16'sd32767);
		send_beat(-16'sd32768, -16'sd32768, -16'sd32768, -16'sd32768, -16'sd32768);
		send_beat(16'sd32767, -16'sd32768, 16'sd32767, -16'sd32768, 16'sd32767);
	endtask

	// CD only and doubled, so the compressor sees half the CD sample
	task automatic knee_beats(input int knee);
		for (int d = -1; d <= 1; d++)
			send_beat(sample_t'(2 * (knee + d)), sample_t'(-2 * (knee + d)),
				16'sd0, 16'sd0, 16'sd0);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [1:0] mode;
		reset = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = REG_SRC_EN;
		cfg_wdata = 8'h00;
		in_valid = 1'b0;
		out_ready = 1'b1;
		cdda_l = '0;
		cdda_r = '0;
		psg_l = '0;
		psg_r = '0;
		adpcm = '0;
		backpressure = 1'b0;
		stall_seen = 1'b0;
		stall_l = '0;
		stall_r = '0;
		sh_src_en = 3'b111;
		sh_cd_boost = 1'b0;
		sh_boost = 2'd0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		#1;
		assert (!out_valid && in_ready)
		else fail_now($sformatf("FAILED at %0t: after reset out_valid %b, in_ready %b",
			$time, out_valid, in_ready));
		check_regs();

		// Default path
		send_random(N_DEFAULT, 1'b0);
		drain();

		// Every source-enable combination
		for (int en = 0; en < 8; en++) begin
			write_reg(REG_SRC_EN, 8'(en));
			check_regs();
			send_random(60, 1'b0);
			drain();
		end
		write_reg(REG_SRC_EN, 8'h07);

		// CD boost, then rails with and without it
		write_reg(REG_BOOST, 8'h01);
		check_regs();
		send_random(40, 1'b0);
		full_scale_beats();
		drain();
		write_reg(REG_BOOST, 8'h00);
		full_scale_beats();
		drain();

		// Compression curves
		for (int m = 1; m <= 2; m++) begin
			mode = 2'(m);
			write_reg(REG_SRC_EN, 8'h07);
			write_reg(REG_BOOST, {5'b0, mode, 1'b0});
			check_regs();
			send_random(50, 1'b0);
			drain();
			write_reg(REG_SRC_EN, 8'h01);
			write_reg(REG_BOOST, {5'b0, mode, 1'b1});
			knee_beats(int'(`AUDIO_COMP1_KNEE));
			knee_beats(int'(`AUDIO_COMP2_KNEE));
			drain();
			write_reg(REG_SRC_EN, 8'h07);
			full_scale_beats();
			drain();
		end

		// Illegal boost code
		write_reg(REG_BOOST, 8'h06);
		check_regs();
		send_random(N_ILLEGAL, 1'b0);
		drain();

		// Back-pressure and input gaps
		write_reg(REG_BOOST, 8'h02);
		backpressure = 1'b1;
		send_random(N_BP, 1'b1);
		drain();
		backpressure = 1'b0;
		idle_cycle();

		if (exp_l_q.size() == 0 && !out_valid) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			fail_now("Beats were still pending at the end of the run");
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the audio path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module audio_tb -f audio_path.f \
	|| { echo "Verilator build failed"; exit 1; }

result=$(./obj_dir/Vaudio_tb 2>&1)
echo "$result"

echo "$result" | grep -q "PASS: all tests" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verilog/audio_cfg_regs.sv
`timescale 1ns/1ps
`include "audio_config.svh"

module audio_cfg_regs (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          cfg_wr,
	input  audio_ctrl_pkg::cfg_addr_e     cfg_addr,
	input  logic [`AUDIO_CFG_DATA_W-1:0]  cfg_wdata,
	output logic [`AUDIO_CFG_DATA_W-1:0]  cfg_rdata,
	output audio_ctrl_pkg::mix_cfg_t      cfg
);
	import audio_ctrl_pkg::*;

	// Bit 0 CD, bit 1 PSG, bit 2 ADPCM
	logic [2:0]  src_en;
	logic        cd_boost;
	boost_mode_e master_boost;

	// Unknown code falls back to no boost
	function automatic boost_mode_e clamp_boost(input logic [1:0] code);
		case (code)
			2'd1: return BOOST_2X;
			2'd2: return BOOST_4X;
			default: return BOOST_OFF;
		endcase
	endfunction

	////////////////////////////////////////
	// Write decode
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src_en       <= `AUDIO_SRC_EN_RESET;
			cd_boost     <= 1'b0;
			master_boost <= BOOST_OFF;
		end else if (cfg_wr) begin
			case (cfg_addr)
				REG_SRC_EN: src_en <= cfg_wdata[2:0];
				REG_BOOST: begin
					cd_boost     <= cfg_wdata[0];
					master_boost <= clamp_boost(cfg_wdata[2:1]);
				end
			endcase
		end
	end

	// Readback, upper bits read as zero
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			REG_SRC_EN: cfg_rdata[2:0] = src_en;
			REG_BOOST:  cfg_rdata[2:0] = {master_boost, cd_boost};
		endcase
	end

	assign cfg.cdda_en      = src_en[0];
	assign cfg.psg_en       = src_en[1];
	assign cfg.adpcm_en     = src_en[2];
	assign cfg.cd_boost     = cd_boost;
	assign cfg.master_boost = master_boost;

	// Compressor only decodes 2x and 4x, so code 3 must never get stored
	a_boost_legal: assert property (
		@(posedge clk_sys) disable iff (reset) master_boost != 2'd3
	);

endmodule

//--- verilog/audio_compressor.sv
`timescale 1ns/1ps
`include "audio_config.svh"

module audio_compressor (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  audio_ctrl_pkg::mix_cfg_t  cfg,
	audio_stream_if.snk               mix_s,
	output logic                      out_valid,
	input  logic                      out_ready,
	output audio_types_pkg::sample_t  out_l,
	output audio_types_pkg::sample_t  out_r
);
	import audio_types_pkg::*;
	import audio_ctrl_pkg::*;

	logic    load;
	sample_t next_l;
	sample_t next_r;

	////////////////////////////////////////
	// Two-knee curve
	////////////////////////////////////////

	// Works on the magnitude, sign restored at the end
	function automatic sample_t compress(input sample_t s, input logic curve2);
		logic [`AUDIO_SAMPLE_W-1:0] mag;
		logic [`AUDIO_SAMPLE_W-1:0] res;
		mag = s[`AUDIO_SAMPLE_W-1] ? ~s + 1'b1 : s;
		if (curve2) begin
			if (mag < `AUDIO_COMP2_KNEE)
				res = mag * `AUDIO_COMP2_GAIN;
			else
				res = (mag - `AUDIO_COMP2_KNEE) / `AUDIO_COMP2_FALL + `AUDIO_COMP2_BASE;
		end else begin
			if (mag < `AUDIO_COMP1_KNEE)
				res = mag * `AUDIO_COMP1_GAIN;
			else
				res = (mag - `AUDIO_COMP1_KNEE) / `AUDIO_COMP1_FALL + `AUDIO_COMP1_BASE;
		end
		return s[`AUDIO_SAMPLE_W-1] ? sample_t'(~res + 1'b1) : sample_t'(res);
	endfunction

	always_comb begin
		case (cfg.master_boost)
			BOOST_2X: begin
				next_l = compress(mix_s.left, 1'b0);
				next_r = compress(mix_s.right, 1'b0);
			end
			BOOST_4X: begin
				next_l = compress(mix_s.left, 1'b1);
				next_r = compress(mix_s.right, 1'b1);
			end
			default: begin
				next_l = mix_s.left;
				next_r = mix_s.right;
			end
		endcase
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	assign load        = ~out_valid | out_ready;
	assign mix_s.ready = load;

	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= mix_s.valid;
	end

	always_ff @(posedge clk_sys) begin
		if (load) begin
			out_l <= next_l;
			out_r <= next_r;
		end
	end

	// Offered beat stays up until the sink takes it
	a_out_hold: assert property (
		@(posedge clk_sys) disable iff (reset) out_valid && !out_ready |=> out_valid
	);

endmodule

//--- verilog/audio_config.svh
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// Datapath widths
`define AUDIO_SAMPLE_W     16
`define AUDIO_SUM_W        18
`define AUDIO_CFG_DATA_W   8

// CD, PSG and ADPCM all enabled out of reset
`define AUDIO_SRC_EN_RESET 3'b111

// Compressor curve 1, used for 2x master boost
`define AUDIO_COMP1_KNEE   16'd14043
`define AUDIO_COMP1_BASE   16'd28086
`define AUDIO_COMP1_GAIN   16'd2
`define AUDIO_COMP1_FALL   16'd4

// Compressor curve 2, used for 4x master boost
`define AUDIO_COMP2_KNEE   16'd7399
`define AUDIO_COMP2_BASE   16'd29596
`define AUDIO_COMP2_GAIN   16'd4
`define AUDIO_COMP2_FALL   16'd8

`endif

//--- verilog/audio_ctrl_pkg.sv
package audio_ctrl_pkg;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////

	// Two registers, one address bit
	typedef enum logic [0:0] {
		REG_SRC_EN = 1'b0,
		REG_BOOST  = 1'b1
	} cfg_addr_e;

	////////////////////////////////////////
	// Master boost
	////////////////////////////////////////

	// Code 3 is not a legal mode
	typedef enum logic [1:0] {
		BOOST_OFF = 2'd0,
		BOOST_2X  = 2'd1,
		BOOST_4X  = 2'd2
	} boost_mode_e;

	////////////////////////////////////////
	// Mixer settings
	////////////////////////////////////////

	typedef struct packed {
		logic        cdda_en;
		logic        psg_en;
		logic        adpcm_en;
		// Doubles CD and skips the 5/4 scale
		logic        cd_boost;
		boost_mode_e master_boost;
	} mix_cfg_t;

endpackage

//--- verilog/audio_mixer.sv
`timescale 1ns/1ps
`include "audio_config.svh"

module audio_mixer (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  audio_ctrl_pkg::mix_cfg_t      cfg,
	input  logic                          in_valid,
	output logic                          in_ready,
	input  audio_types_pkg::src_samples_t in_samples,
	audio_stream_if.src                   mix_s
);
	import audio_types_pkg::*;
	import audio_ctrl_pkg::*;

	localparam int EXT_W = `AUDIO_SUM_W - `AUDIO_SAMPLE_W;

	// Stage 1 holds the pre-sums
	logic     s1_valid;
	logic     s1_load;
	mix_sum_t pre_l;
	mix_sum_t pre_r;

	// Stage 2 holds the scaled output
	logic     s2_valid;
	logic     s2_load;
	sample_t  mix_l;
	sample_t  mix_r;

	sample_t  adpcm_att;
	mix_sum_t scaled_l;
	mix_sum_t scaled_r;

	function automatic mix_sum_t widen(input sample_t s);
		return {{EXT_W{s[`AUDIO_SAMPLE_W-1]}}, s};
	endfunction

	// 1/2 + 1/4 + 1/16
	function automatic sample_t atten_psg(input sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 4);
	endfunction

	// 1/2 + 1/4 + 1/8
	function automatic sample_t atten_adpcm(input sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 3);
	endfunction

	function automatic mix_sum_t pre_sum(
		input sample_t  cd,
		input sample_t  psg,
		input sample_t  adp,
		input mix_cfg_t c
	);
		mix_sum_t acc;
		acc = '0;
		if (c.cdda_en)
			acc = acc + widen(cd);
		// Second CD term gives the 2x boost
		if (c.cdda_en && c.cd_boost)
			acc = acc + widen(cd);
		if (c.psg_en)
			acc = acc + widen(atten_psg(psg));
		if (c.adpcm_en)
			acc = acc + widen(adp);
		return acc;
	endfunction

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	assign s2_load  = ~s2_valid | mix_s.ready;
	assign s1_load  = ~s1_valid | s2_load;
	assign in_ready = s1_load;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_load)
				s1_valid <= in_valid;
			if (s2_load)
				s2_valid <= s1_valid;
		end
	end

	////////////////////////////////////////
	// Stage 1 attenuate and sum
	////////////////////////////////////////

	// Mono ADPCM feeds both channels
	assign adpcm_att = atten_adpcm(in_samples.adpcm);

	always_ff @(posedge clk_sys) begin
		if (s1_load) begin
			pre_l <= pre_sum(in_samples.cdda_l, in_samples.psg_l, adpcm_att, cfg);
			pre_r <= pre_sum(in_samples.cdda_r, in_samples.psg_r, adpcm_att, cfg);
		end
	end

	////////////////////////////////////////
	// Stage 2 headroom scale
	////////////////////////////////////////

	// 5/4 scale wraps in 18 bits, skipped when CD is boosted
	assign scaled_l = cfg.cd_boost ? pre_l : pre_l + (pre_l >>> 2);
	assign scaled_r = cfg.cd_boost ? pre_r : pre_r + (pre_r >>> 2);

	always_ff @(posedge clk_sys) begin
		if (s2_load) begin
			mix_l <= scaled_l[`AUDIO_SUM_W-1 -: `AUDIO_SAMPLE_W];
			mix_r <= scaled_r[`AUDIO_SUM_W-1 -: `AUDIO_SAMPLE_W];
		end
	end

	assign mix_s.valid = s2_valid;
	assign mix_s.left  = mix_l;
	assign mix_s.right = mix_r;

	// Stalled beat toward the compressor must hold
	a_mix_hold: assert property (
		@(posedge clk_sys) disable iff (reset)
		mix_s.valid && !mix_s.ready |=>
			mix_s.valid && $stable(mix_s.left) && $stable(mix_s.right)
	);

endmodule

//--- verilog/audio_stream_if.sv
`timescale 1ns/1ps

interface audio_stream_if;
	import audio_types_pkg::*;

	// Beat moves when valid and ready are both high
	logic    valid;
	logic    ready;
	sample_t left;
	sample_t right;

	// Producer side
	modport src (
		output valid, left, right,
		input  ready
	);

	// Consumer side
	modport snk (
		input  valid, left, right,
		output ready
	);

endinterface

//--- verilog/audio_top.sv
`timescale 1ns/1ps
`include "audio_config.svh"

module audio_top (
	input  logic                          clk_sys,
	input  logic                          reset,

	// Register port
	input  logic                          cfg_wr,
	input  audio_ctrl_pkg::cfg_addr_e     cfg_addr,
	input  logic [`AUDIO_CFG_DATA_W-1:0]  cfg_wdata,
	output logic [`AUDIO_CFG_DATA_W-1:0]  cfg_rdata,

	// Source beat
	input  logic                          in_valid,
	output logic                          in_ready,
	input  audio_types_pkg::sample_t      cdda_l,
	input  audio_types_pkg::sample_t      cdda_r,
	input  audio_types_pkg::sample_t      psg_l,
	input  audio_types_pkg::sample_t      psg_r,
	input  audio_types_pkg::sample_t      adpcm,

	// Mixed output
	output logic                          out_valid,
	input  logic                          out_ready,
	output audio_types_pkg::sample_t      out_l,
	output audio_types_pkg::sample_t      out_r
);
	import audio_types_pkg::*;
	import audio_ctrl_pkg::*;

	mix_cfg_t     cfg;
	src_samples_t in_samples;

	audio_stream_if mix_s ();

	assign in_samples = '{
		cdda_l: cdda_l,
		cdda_r: cdda_r,
		psg_l:  psg_l,
		psg_r:  psg_r,
		adpcm:  adpcm
	};

	audio_cfg_regs cfg_regs_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.cfg       (cfg)
	);

	audio_mixer mixer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg        (cfg),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_samples (in_samples),
		.mix_s      (mix_s.src)
	);

	audio_compressor compressor_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cfg       (cfg),
		.mix_s     (mix_s.snk),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_l     (out_l),
		.out_r     (out_r)
	);

endmodule

//--- verilog/audio_types_pkg.sv
`include "audio_config.svh"

package audio_types_pkg;

	////////////////////////////////////////
	// Sample and accumulator types
	////////////////////////////////////////

	// One signed PCM sample
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// Room for up to four sample terms
	typedef logic signed [`AUDIO_SUM_W-1:0] mix_sum_t;

	////////////////////////////////////////
	// Input beat
	////////////////////////////////////////

	// Stereo CD, stereo PSG, mono ADPCM
	typedef struct packed {
		sample_t cdda_l;
		sample_t cdda_r;
		sample_t psg_l;
		sample_t psg_r;
		sample_t adpcm;
	} src_samples_t;

endpackage
